// ==== design/core_pkg.sv ====
//==========================================================================
// Widths, sizes and the ALU operation encoding of the rename back end.
// RTL and testbench refer to these through core_pkg:: scoped names.
//==========================================================================
`default_nettype none

package core_pkg;

  // architectural registers, x0 reads zero
  localparam int arch_reg_w    = 3;
  localparam int num_arch_regs = 8;
  typedef logic [arch_reg_w-1:0] arch_reg_t;

  // physical registers, p0 stays bound to x0 and is never allocated
  localparam int phys_reg_w    = 4;
  localparam int num_phys_regs = 16;
  typedef logic [phys_reg_w-1:0] phys_reg_t;

  // operand, immediate and result width
  localparam int xlen = 32;
  typedef logic [xlen-1:0] data_t;

  // in-order issue queue entries
  localparam int iq_depth = 4;

  // shifts take the low 5 bits of operand b, slt is signed
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_sll = 3'd5,
    alu_srl = 3'd6,
    alu_slt = 3'd7
  } alu_op_t;

endpackage

`default_nettype wire

// ==== design/rename_table.sv ====
//==========================================================================
// Register alias table and circular free list. Renames one micro-op per
// accepted handshake and takes displaced physical registers back at
// write-back, which is also retirement in this core.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module rename_table (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       uop_valid,
  input  var  core_pkg::alu_op_t    uop_op,
  input  wire core_pkg::arch_reg_t  uop_rs1,
  input  wire core_pkg::arch_reg_t  uop_rs2,
  input  wire core_pkg::arch_reg_t  uop_rd,
  input  wire                       uop_use_imm,
  input  wire core_pkg::data_t      uop_imm,
  input  wire                       iq_full,
  input  wire                       wb_valid,
  input  wire                       wb_write,
  input  wire core_pkg::phys_reg_t  wb_old_pd,
  output logic                      uop_ready,
  output logic                      ren_valid,
  output core_pkg::alu_op_t         ren_op,
  output logic                      ren_use_imm,
  output core_pkg::data_t           ren_imm,
  output core_pkg::phys_reg_t       ren_ps1,
  output core_pkg::phys_reg_t       ren_ps2,
  output core_pkg::phys_reg_t       ren_pd,
  output core_pkg::phys_reg_t       ren_old_pd,
  output core_pkg::arch_reg_t       ren_rd,
  output logic                      ren_write
);

  core_pkg::phys_reg_t             alias_map [core_pkg::num_arch_regs];
  core_pkg::phys_reg_t             free_mem  [core_pkg::num_phys_regs];
  core_pkg::phys_reg_t             free_head;
  core_pkg::phys_reg_t             free_tail;
  logic [core_pkg::phys_reg_w:0]   free_count;
  logic                            free_empty;
  logic                            pop;
  logic                            push;

  assign free_empty = (free_count == '0);
  // x0 destinations need no free register
  assign uop_ready  = (!free_empty || (uop_rd == '0)) && !iq_full && !reset;
  assign ren_valid  = uop_valid && uop_ready;
  assign ren_write  = (uop_rd != '0);
  assign pop        = ren_valid && ren_write;
  assign push       = wb_valid && wb_write && (wb_old_pd != '0);

  // sources see the mapping before this micro-op's own update
  assign ren_op      = uop_op;
  assign ren_use_imm = uop_use_imm;
  assign ren_imm     = uop_imm;
  assign ren_ps1     = alias_map[uop_rs1];
  assign ren_ps2     = uop_use_imm ? '0 : alias_map[uop_rs2];
  assign ren_pd      = ren_write ? free_mem[free_head] : '0;
  assign ren_old_pd  = alias_map[uop_rd];
  assign ren_rd      = uop_rd;

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map with p8..p15 free
      for (int i = 0; i < core_pkg::num_arch_regs; i++)
        alias_map[i] <= core_pkg::phys_reg_t'(i);
      for (int i = 0; i < core_pkg::num_phys_regs; i++)
        free_mem[i] <= core_pkg::phys_reg_t'(i + core_pkg::num_arch_regs);
      free_head  <= '0;
      free_tail  <= core_pkg::phys_reg_t'(core_pkg::num_phys_regs - core_pkg::num_arch_regs);
      free_count <= (core_pkg::phys_reg_w + 1)'(core_pkg::num_phys_regs
                                                - core_pkg::num_arch_regs);
    end else begin
      if (pop) begin
        alias_map[uop_rd] <= free_mem[free_head];
        free_head         <= free_head + 1'b1;
      end
      if (push) begin
        free_mem[free_tail] <= wb_old_pd;
        free_tail           <= free_tail + 1'b1;
      end
      if (pop && !push)
        free_count <= free_count - 1'b1;
      else if (push && !pop)
        free_count <= free_count + 1'b1;
    end
  end

  // at most eight free entries, so equal pointers mean empty
  a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
    pop |-> (free_head != free_tail));

  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    (push && !pop) |-> (free_count < core_pkg::num_phys_regs));

  // a writing micro-op always displaces an allocated register
  a_no_push_p0: assert property (@(posedge clock) disable iff (reset)
    (wb_valid && wb_write) |-> (wb_old_pd != '0));

endmodule

`default_nettype wire

// ==== design/scoreboard.sv ====
//==========================================================================
// Busy bit per physical register. Rename marks a new destination busy and
// write-back clears it. The issue queue looks up its head's sources here.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module scoreboard (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       set_valid,
  input  wire core_pkg::phys_reg_t  set_pd,
  input  wire                       clear_valid,
  input  wire core_pkg::phys_reg_t  clear_pd,
  input  wire core_pkg::phys_reg_t  ps1,
  input  wire core_pkg::phys_reg_t  ps2,
  output logic                      ps1_busy,
  output logic                      ps2_busy
);

  logic [core_pkg::num_phys_regs-1:0] busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (clear_valid)
        busy[clear_pd] <= 1'b0;
      // p0 is the x0 mapping and never waits
      if (set_valid && (set_pd != '0))
        busy[set_pd] <= 1'b1;
    end
  end

  assign ps1_busy = busy[ps1];
  assign ps2_busy = busy[ps2];

  // free list must only hand out registers whose last producer retired
  a_set_not_busy: assert property (@(posedge clock) disable iff (reset)
    (set_valid && (set_pd != '0)) |-> !busy[set_pd]);

endmodule

`default_nettype wire

// ==== design/issue_queue.sv ====
//==========================================================================
// In-order queue of renamed micro-ops. Only the head may issue, once both
// its sources are no longer busy and the ALU pipe can take it.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module issue_queue (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       push,
  input  var  core_pkg::alu_op_t    ren_op,
  input  wire                       ren_use_imm,
  input  wire core_pkg::data_t      ren_imm,
  input  wire core_pkg::phys_reg_t  ren_ps1,
  input  wire core_pkg::phys_reg_t  ren_ps2,
  input  wire core_pkg::phys_reg_t  ren_pd,
  input  wire core_pkg::phys_reg_t  ren_old_pd,
  input  wire core_pkg::arch_reg_t  ren_rd,
  input  wire                       ren_write,
  input  wire                       ps1_busy,
  input  wire                       ps2_busy,
  input  wire                       pipe_advance,
  output logic                      full,
  output core_pkg::phys_reg_t       head_ps1,
  output core_pkg::phys_reg_t       head_ps2,
  output logic                      iss_valid,
  output core_pkg::alu_op_t         iss_op,
  output logic                      iss_use_imm,
  output core_pkg::data_t           iss_imm,
  output core_pkg::phys_reg_t       iss_ps1,
  output core_pkg::phys_reg_t       iss_ps2,
  output core_pkg::phys_reg_t       iss_pd,
  output core_pkg::phys_reg_t       iss_old_pd,
  output core_pkg::arch_reg_t       iss_rd,
  output logic                      iss_write
);

  core_pkg::alu_op_t                    q_op      [core_pkg::iq_depth];
  logic                                 q_use_imm [core_pkg::iq_depth];
  core_pkg::data_t                      q_imm     [core_pkg::iq_depth];
  core_pkg::phys_reg_t                  q_ps1     [core_pkg::iq_depth];
  core_pkg::phys_reg_t                  q_ps2     [core_pkg::iq_depth];
  core_pkg::phys_reg_t                  q_pd      [core_pkg::iq_depth];
  core_pkg::phys_reg_t                  q_old_pd  [core_pkg::iq_depth];
  core_pkg::arch_reg_t                  q_rd      [core_pkg::iq_depth];
  logic                                 q_write   [core_pkg::iq_depth];
  logic [$clog2(core_pkg::iq_depth)-1:0] head;
  logic [$clog2(core_pkg::iq_depth)-1:0] tail;
  logic [$clog2(core_pkg::iq_depth):0]   count;

  assign full     = (count == core_pkg::iq_depth);
  assign head_ps1 = q_ps1[head];
  assign head_ps2 = q_ps2[head];

  // younger entries wait behind a stalled head
  assign iss_valid   = (count != '0) && !ps1_busy && !ps2_busy && pipe_advance;
  assign iss_op      = q_op[head];
  assign iss_use_imm = q_use_imm[head];
  assign iss_imm     = q_imm[head];
  assign iss_ps1     = q_ps1[head];
  assign iss_ps2     = q_ps2[head];
  assign iss_pd      = q_pd[head];
  assign iss_old_pd  = q_old_pd[head];
  assign iss_rd      = q_rd[head];
  assign iss_write   = q_write[head];

  always_ff @(posedge clock) begin
    if (push) begin
      q_op[tail]      <= ren_op;
      q_use_imm[tail] <= ren_use_imm;
      q_imm[tail]     <= ren_imm;
      q_ps1[tail]     <= ren_ps1;
      q_ps2[tail]     <= ren_ps2;
      q_pd[tail]      <= ren_pd;
      q_old_pd[tail]  <= ren_old_pd;
      q_rd[tail]      <= ren_rd;
      q_write[tail]   <= ren_write;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push)
        tail <= tail + 1'b1;
      if (iss_valid)
        head <= head + 1'b1;
      if (push && !iss_valid)
        count <= count + 1'b1;
      else if (iss_valid && !push)
        count <= count - 1'b1;
    end
  end

  // a push into a non-empty queue must not land on the head entry
  a_no_push_full: assert property (@(posedge clock) disable iff (reset)
    (push && (count != '0)) |-> (tail != head));

endmodule

`default_nettype wire

// ==== design/prf_int.sv ====
//==========================================================================
// Physical integer register file, two registered read ports and one
// write port fed from ALU write-back.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module prf_int (
  input  wire                       clock,
  input  wire                       reset,
  input  wire core_pkg::phys_reg_t  rd_addr1,
  input  wire core_pkg::phys_reg_t  rd_addr2,
  input  wire                       wr_valid,
  input  wire core_pkg::phys_reg_t  wr_addr,
  input  wire core_pkg::data_t      wr_data,
  output core_pkg::data_t           rd_data1,
  output core_pkg::data_t           rd_data2
);

  core_pkg::data_t regs [core_pkg::num_phys_regs];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::num_phys_regs; i++)
        regs[i] <= '0;
    end else if (wr_valid) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // p0 holds x0
  always_ff @(posedge clock) begin
    rd_data1 <= (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    rd_data2 <= (rd_addr2 == '0) ? '0 : regs[rd_addr2];
  end

  a_no_write_p0: assert property (@(posedge clock) disable iff (reset)
    wr_valid |-> (wr_addr != '0));

endmodule

`default_nettype wire

// ==== design/alu_pipe.sv ====
//==========================================================================
// Two-stage ALU pipe. Stage 1 waits for the register file read, stage 2
// computes and holds the result until the result port takes it.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module alu_pipe (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       iss_valid,
  input  var  core_pkg::alu_op_t    iss_op,
  input  wire                       iss_use_imm,
  input  wire core_pkg::data_t      iss_imm,
  input  wire core_pkg::phys_reg_t  iss_pd,
  input  wire core_pkg::phys_reg_t  iss_old_pd,
  input  wire core_pkg::arch_reg_t  iss_rd,
  input  wire                       iss_write,
  input  wire core_pkg::data_t      rs1_data,
  input  wire core_pkg::data_t      rs2_data,
  input  wire                       result_ready,
  output logic                      advance,
  output logic                      wb_valid,
  output core_pkg::phys_reg_t       wb_pd,
  output core_pkg::arch_reg_t       wb_rd,
  output logic                      wb_write,
  output core_pkg::phys_reg_t       wb_old_pd,
  output core_pkg::data_t           wb_data
);

  logic                 s1_valid;
  logic                 s1_fresh;
  core_pkg::alu_op_t    s1_op;
  logic                 s1_use_imm;
  core_pkg::data_t      s1_imm;
  core_pkg::phys_reg_t  s1_pd;
  core_pkg::phys_reg_t  s1_old_pd;
  core_pkg::arch_reg_t  s1_rd;
  logic                 s1_write;
  core_pkg::data_t      s1_a;
  core_pkg::data_t      s1_b;
  core_pkg::data_t      op_a;
  core_pkg::data_t      op_b;
  core_pkg::data_t      alu_result;

  // whole pipe freezes while stage 2 waits on the result port
  assign advance = !wb_valid || result_ready;

  // read data is live only right after stage 1 loads, kept in s1_a/s1_b later
  assign op_a = s1_fresh ? rs1_data : s1_a;
  assign op_b = s1_use_imm ? s1_imm : (s1_fresh ? rs2_data : s1_b);

  always_comb begin
    case (s1_op)
      core_pkg::alu_add: alu_result = op_a + op_b;
      core_pkg::alu_sub: alu_result = op_a - op_b;
      core_pkg::alu_and: alu_result = op_a & op_b;
      core_pkg::alu_or:  alu_result = op_a | op_b;
      core_pkg::alu_xor: alu_result = op_a ^ op_b;
      core_pkg::alu_sll: alu_result = op_a << op_b[4:0];
      core_pkg::alu_srl: alu_result = op_a >> op_b[4:0];
      core_pkg::alu_slt: alu_result = core_pkg::data_t'($signed(op_a) < $signed(op_b));
      default:           alu_result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_fresh <= 1'b0;
      wb_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= iss_valid;
      s1_fresh <= 1'b1;
      wb_valid <= s1_valid;
    end else begin
      s1_fresh <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      s1_op      <= iss_op;
      s1_use_imm <= iss_use_imm;
      s1_imm     <= iss_imm;
      s1_pd      <= iss_pd;
      s1_old_pd  <= iss_old_pd;
      s1_rd      <= iss_rd;
      s1_write   <= iss_write;
      wb_pd      <= s1_pd;
      wb_rd      <= s1_rd;
      wb_write   <= s1_write;
      wb_old_pd  <= s1_old_pd;
      wb_data    <= alu_result;
    end else if (s1_fresh) begin
      s1_a <= rs1_data;
      s1_b <= rs2_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/rename_core.sv ====
//==========================================================================
// Rename back end top. Micro-ops enter through a valid/ready port, pass
// rename, in-order issue, register read and the ALU pipe, and leave in
// program order on the result port.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module rename_core (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       uop_valid,
  input  var  core_pkg::alu_op_t    uop_op,
  input  wire core_pkg::arch_reg_t  uop_rs1,
  input  wire core_pkg::arch_reg_t  uop_rs2,
  input  wire core_pkg::arch_reg_t  uop_rd,
  input  wire                       uop_use_imm,
  input  wire core_pkg::data_t      uop_imm,
  input  wire                       result_ready,
  output logic                      uop_ready,
  output logic                      result_valid,
  output core_pkg::arch_reg_t       result_rd,
  output core_pkg::data_t           result_data
);

  logic ren_valid, ren_use_imm, ren_write;
  core_pkg::alu_op_t   ren_op;
  core_pkg::data_t     ren_imm;
  core_pkg::phys_reg_t ren_ps1, ren_ps2, ren_pd, ren_old_pd;
  core_pkg::arch_reg_t ren_rd;

  logic iq_full, ps1_busy, ps2_busy;
  core_pkg::phys_reg_t head_ps1, head_ps2;

  logic iss_valid, iss_use_imm, iss_write;
  core_pkg::alu_op_t   iss_op;
  core_pkg::data_t     iss_imm;
  core_pkg::phys_reg_t iss_ps1, iss_ps2, iss_pd, iss_old_pd;
  core_pkg::arch_reg_t iss_rd;

  core_pkg::data_t     rs1_data, rs2_data;
  logic                advance, wb_write;
  core_pkg::phys_reg_t wb_pd, wb_old_pd;

  // write-back happens when the result port takes stage 2
  logic wb_done, prf_we;
  assign wb_done = result_valid && result_ready;
  assign prf_we  = wb_done && wb_write;

  rename_table rename0 (
    .clock(clock), .reset(reset), .uop_valid(uop_valid), .uop_op(uop_op),
    .uop_rs1(uop_rs1), .uop_rs2(uop_rs2), .uop_rd(uop_rd),
    .uop_use_imm(uop_use_imm), .uop_imm(uop_imm), .iq_full(iq_full),
    .wb_valid(wb_done), .wb_write(wb_write), .wb_old_pd(wb_old_pd),
    .uop_ready(uop_ready), .ren_valid(ren_valid), .ren_op(ren_op),
    .ren_use_imm(ren_use_imm), .ren_imm(ren_imm), .ren_ps1(ren_ps1),
    .ren_ps2(ren_ps2), .ren_pd(ren_pd), .ren_old_pd(ren_old_pd),
    .ren_rd(ren_rd), .ren_write(ren_write)
  );

  // non-writing micro-ops carry pd 0, which the scoreboard ignores
  scoreboard sb0 (
    .clock(clock), .reset(reset), .set_valid(ren_valid), .set_pd(ren_pd),
    .clear_valid(wb_done), .clear_pd(wb_pd), .ps1(head_ps1), .ps2(head_ps2),
    .ps1_busy(ps1_busy), .ps2_busy(ps2_busy)
  );

  issue_queue iq0 (
    .clock(clock), .reset(reset), .push(ren_valid), .ren_op(ren_op),
    .ren_use_imm(ren_use_imm), .ren_imm(ren_imm), .ren_ps1(ren_ps1),
    .ren_ps2(ren_ps2), .ren_pd(ren_pd), .ren_old_pd(ren_old_pd),
    .ren_rd(ren_rd), .ren_write(ren_write), .ps1_busy(ps1_busy),
    .ps2_busy(ps2_busy), .pipe_advance(advance), .full(iq_full),
    .head_ps1(head_ps1), .head_ps2(head_ps2), .iss_valid(iss_valid),
    .iss_op(iss_op), .iss_use_imm(iss_use_imm), .iss_imm(iss_imm),
    .iss_ps1(iss_ps1), .iss_ps2(iss_ps2), .iss_pd(iss_pd),
    .iss_old_pd(iss_old_pd), .iss_rd(iss_rd), .iss_write(iss_write)
  );

  prf_int prf0 (
    .clock(clock), .reset(reset), .rd_addr1(iss_ps1), .rd_addr2(iss_ps2),
    .wr_valid(prf_we), .wr_addr(wb_pd), .wr_data(result_data),
    .rd_data1(rs1_data), .rd_data2(rs2_data)
  );

  alu_pipe alu0 (
    .clock(clock), .reset(reset), .iss_valid(iss_valid), .iss_op(iss_op),
    .iss_use_imm(iss_use_imm), .iss_imm(iss_imm), .iss_pd(iss_pd),
    .iss_old_pd(iss_old_pd), .iss_rd(iss_rd), .iss_write(iss_write),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .result_ready(result_ready),
    .advance(advance), .wb_valid(result_valid), .wb_pd(wb_pd),
    .wb_rd(result_rd), .wb_write(wb_write), .wb_old_pd(wb_old_pd),
    .wb_data(result_data)
  );

endmodule

`default_nettype wire

// ==== verif/rename_core_tb.sv ====
//==========================================================================
// Testbench for the rename back end. Micro-ops and their expected results
// come from the stim file; results are checked in order while the result
// port is throttled at random.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module rename_core_tb;

  localparam int max_ops       = 64;
  localparam int stim_cols     = 7;
  localparam int cycles_per_op = 40;
  localparam int reset_cycles  = 8;

  logic                clock;
  logic                reset;
  logic                uop_valid;
  core_pkg::alu_op_t   uop_op;
  core_pkg::arch_reg_t uop_rs1;
  core_pkg::arch_reg_t uop_rs2;
  core_pkg::arch_reg_t uop_rd;
  logic                uop_use_imm;
  core_pkg::data_t     uop_imm;
  logic                result_ready;
  logic                uop_ready;
  logic                result_valid;
  core_pkg::arch_reg_t result_rd;
  core_pkg::data_t     result_data;

  // seven hex words per micro-op as laid out in the stim file
  core_pkg::data_t stim_mem [max_ops*stim_cols];
  int              n_ops    = 0;
  int              sent     = 0;
  int              received = 0;
  logic            loaded   = 1'b0;

  rename_core dut0 (
    .clock(clock), .reset(reset), .uop_valid(uop_valid), .uop_op(uop_op),
    .uop_rs1(uop_rs1), .uop_rs2(uop_rs2), .uop_rd(uop_rd),
    .uop_use_imm(uop_use_imm), .uop_imm(uop_imm), .result_ready(result_ready),
    .uop_ready(uop_ready), .result_valid(result_valid), .result_rd(result_rd),
    .result_data(result_data)
  );

  always #10 clock = ~clock;

  function automatic core_pkg::data_t stim_field(input int idx, input int col);
    return stim_mem[idx*stim_cols + col];
  endfunction

  task automatic end_with_failure();
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input core_pkg::data_t expected,
                            input core_pkg::data_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_reg(input string name, input core_pkg::arch_reg_t expected,
                           input core_pkg::arch_reg_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected x%0d, actual x%0d", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic present_uop(input int idx);
    uop_op      <= core_pkg::alu_op_t'(stim_mem[idx*stim_cols][2:0]);
    uop_rs1     <= core_pkg::arch_reg_t'(stim_field(idx, 1));
    uop_rs2     <= core_pkg::arch_reg_t'(stim_field(idx, 2));
    uop_rd      <= core_pkg::arch_reg_t'(stim_field(idx, 3));
    uop_use_imm <= stim_mem[idx*stim_cols + 4][0];
    uop_imm     <= stim_field(idx, 5);
    uop_valid   <= 1'b1;
  endtask

  initial begin : main
    void'($urandom(63));
    clock        = 1'b0;
    reset        = 1'b1;
    uop_valid    = 1'b0;
    uop_op       = core_pkg::alu_add;
    uop_rs1      = '0;
    uop_rs2      = '0;
    uop_rd       = '0;
    uop_use_imm  = 1'b0;
    uop_imm      = '0;
    result_ready = 1'b0;

    $readmemh("verif/rename_core_stim.txt", stim_mem);
    while (n_ops < max_ops && stim_mem[n_ops*stim_cols] !== 'x)
      n_ops++;
    if (n_ops == 0) begin
      $display("stim file could not be read or holds no micro-ops");
      end_with_failure();
    end
    loaded = 1'b1;

    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    if (uop_ready !== 1'b1 || result_valid !== 1'b0) begin
      $display("core not idle and ready in the first cycle after reset");
      end_with_failure();
    end

    // hold a refused micro-op and idle now and then
    while (sent < n_ops) begin
      @(posedge clock);
      if (uop_valid && uop_ready) begin
        sent++;
        uop_valid <= 1'b0;
      end
      if (sent < n_ops && !(uop_valid && !uop_ready) && ($urandom % 4 != 0))
        present_uop(sent);
    end

    wait (received == n_ops);
    // the result port stays quiet once every micro-op is answered
    repeat (10) begin
      @(posedge clock);
      if (result_valid) begin
        $display("result_valid rose after every micro-op was already answered");
        end_with_failure();
      end
    end
    $display("Verification passed");
    $finish;
  end

  initial begin : ready_driver
    int mode;
    wait (loaded && !reset);
    forever begin
      mode = $urandom % 3;
      repeat (24) begin
        @(posedge clock);
        case (mode)
          0:       result_ready <= 1'b1;
          1:       result_ready <= ($urandom % 2 == 0);
          default: result_ready <= 1'b0;
        endcase
      end
    end
  end

  initial begin : receiver
    wait (loaded && !reset);
    forever begin
      @(posedge clock);
      if (result_valid && result_ready) begin
        if (received >= n_ops) begin
          $display("a result arrived after every micro-op was already answered");
          end_with_failure();
        end
        check_reg($sformatf("uop %0d rd", received),
                  core_pkg::arch_reg_t'(stim_field(received, 3)), result_rd);
        check_data($sformatf("uop %0d data", received),
                   stim_field(received, 6), result_data);
        received++;
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (n_ops*cycles_per_op + reset_cycles) @(posedge clock);
    $display("timeout: results stopped arriving, %0d of %0d received", received, n_ops);
    end_with_failure();
  end

endmodule

`default_nettype wire

// ==== rename_core.f ====
design/core_pkg.sv
design/rename_table.sv
design/scoreboard.sv
design/issue_queue.sv
design/prf_int.sv
design/alu_pipe.sv
design/rename_core.sv
verif/rename_core_tb.sv

// ==== verif/rename_core_stim.txt ====
// columns (hex): op rs1 rs2 rd use_imm imm expected_result
// op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 slt
0 0 0 1 1 00001234 00001234
0 0 0 2 1 FFFFFFF0 FFFFFFF0
0 1 2 3 0 00000000 00001224
1 3 1 4 0 00000000 FFFFFFF0
2 1 0 5 1 0000FF0F 00001204
3 5 2 6 0 00000000 FFFFFFF4
4 6 0 7 1 0F0F0F0F F0F0F0FB
5 1 0 1 1 00000004 00012340
6 2 0 2 1 00000024 0FFFFFFF
7 4 1 3 0 00000000 00000001
7 1 4 4 0 00000000 00000000
5 3 7 5 0 00000000 08000000
6 6 3 6 0 00000000 7FFFFFFA
0 1 2 0 0 00000000 1001233F
0 0 0 7 1 00000005 00000005
3 0 0 1 0 00000000 00000000
7 0 0 2 1 FFFFFFFF 00000000
1 7 0 0 1 00000001 00000004
0 7 7 3 0 00000000 0000000A
0 3 3 3 0 00000000 00000014
0 3 3 3 0 00000000 00000028
0 3 0 3 1 00000002 0000002A
4 3 5 4 0 00000000 0800002A
1 0 4 5 0 00000000 F7FFFFD6
7 5 4 6 0 00000000 00000001
6 5 0 7 1 0000001F 00000001
2 5 6 1 0 00000000 00000000
5 4 7 2 0 00000000 10000054
